//--- rtl/cmd_pkg.sv
package cmd_pkg;

    // Byte and result widths
    localparam int DATA_W    = 8;              // One UART frame
    localparam int ALU_OUT_W = 16;             // Full ALU result

    typedef logic [DATA_W-1:0]    data_t;      // Received or transmitted byte
    typedef logic [ALU_OUT_W-1:0] alu_out_t;   // ALU result

    // Command bytes seen in idle
    localparam data_t CMD_RF_WR   = 8'hAA;     // Write: addr, data
    localparam data_t CMD_RF_RD   = 8'hBB;     // Read: addr
    localparam data_t CMD_ALU_OP  = 8'hCC;     // ALU: A, B, function
    localparam data_t CMD_ALU_NOP = 8'hDD;     // ALU on current reg 0/1: function

    // ALU function codes, low nibble of the function frame
    typedef enum logic [3:0] {
        FUN_ADD = 4'd0,
        FUN_SUB = 4'd1,
        FUN_MUL = 4'd2,
        FUN_DIV = 4'd3,
        FUN_AND = 4'd4,
        FUN_OR  = 4'd5,
        FUN_XOR = 4'd6,
        FUN_EQ  = 4'd7,
        FUN_GT  = 4'd8,
        FUN_SHR = 4'd9,
        FUN_SHL = 4'd10
    } alu_fun_e;

    // What the executor is asked to do
    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_ALU} op_kind_e;

    // Decoder to executor, 22 bits
    typedef struct packed {
        op_kind_e kind;
        data_t    addr;                        // Raw address byte
        data_t    data;                        // Write data
        alu_fun_e fun;
    } op_t;

    // Executor to serializer, 17 bits
    typedef struct packed {
        alu_out_t value;
        logic     two_bytes;                   // ALU result, else single read byte
    } rsp_t;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file import cmd_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  data_t                 wr_data,
    output data_t                 rd_data,   // Valid the cycle after rd_en
    output data_t                 reg0,      // ALU operand A
    output data_t                 reg1       // ALU operand B
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    data_t mem [DEPTH];

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end
            // Registered read port
            if (rd_en) begin
                rd_data <= mem[addr];
            end
        end
    end

    // Operands seen by the ALU at all times
    assign reg0 = mem[0];
    assign reg1 = mem[1];

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit import cmd_pkg::*; (
    input  data_t    opa,
    input  data_t    opb,
    input  alu_fun_e fun,
    output alu_out_t result
);

    alu_out_t a;
    alu_out_t b;

    // Both operands zero-extended to result width
    assign a = {{(ALU_OUT_W - DATA_W){1'b0}}, opa};
    assign b = {{(ALU_OUT_W - DATA_W){1'b0}}, opb};

    always_comb begin
        unique case (fun)
            FUN_ADD: result = a + b;
            FUN_SUB: result = a - b;                      // Wraps mod 2^16
            FUN_MUL: result = a * b;                      // 8x8 fits in 16
            FUN_DIV: begin
                if (b == '0) begin
                    result = '0;                          // Divide by zero gives 0
                end else begin
                    result = a / b;
                end
            end
            FUN_AND: result = a & b;
            FUN_OR:  result = a | b;
            FUN_XOR: result = a ^ b;
            FUN_EQ:  result = alu_out_t'(a == b);
            FUN_GT:  result = alu_out_t'(a > b);
            FUN_SHR: result = a >> 1;
            FUN_SHL: result = a << 1;                     // Bit 8 survives
            default: result = '0;                         // Codes 11..15
        endcase
    end

endmodule

//--- rtl/frame_decoder.sv
`timescale 1ns/10ps

module frame_decoder import cmd_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  logic  rx_valid,     // One-cycle strobe per received byte
    input  data_t rx_data,
    output logic  op_valid,
    output op_t   op,
    input  logic  op_ready
);

    // Frame position within a command
    typedef enum logic [1:0] {S_IDLE, S_FIRST, S_SECOND, S_FUNC} state_e;
    // Command seen in idle
    typedef enum logic [1:0] {K_WR, K_RD, K_ALU} kind_e;

    state_e state_q, state_d;
    kind_e  kind_q, kind_d;
    data_t  waddr_q;            // Write address held until the data frame
    logic   waddr_en;
    logic   take;               // Byte is consumed this cycle
    logic   emit;               // Byte completes an operation
    op_t    op_d;

    // Drop bytes while an operation is stuck waiting for the executor
    assign take = rx_valid && !(op_valid && !op_ready);

    always_comb begin
        state_d   = state_q;
        kind_d    = kind_q;
        waddr_en  = 1'b0;
        emit      = 1'b0;
        op_d.kind = OP_WRITE;
        op_d.addr = rx_data;
        op_d.data = rx_data;
        op_d.fun  = alu_fun_e'(rx_data[3:0]);   // Only the low nibble counts
        if (take) begin
            unique case (state_q)
                S_IDLE: begin
                    case (rx_data)
                        CMD_RF_WR: begin
                            kind_d  = K_WR;
                            state_d = S_FIRST;
                        end
                        CMD_RF_RD: begin
                            kind_d  = K_RD;
                            state_d = S_FIRST;
                        end
                        CMD_ALU_OP: begin
                            kind_d  = K_ALU;
                            state_d = S_FIRST;
                        end
                        CMD_ALU_NOP: begin
                            kind_d  = K_ALU;
                            state_d = S_FUNC;   // No operand frames
                        end
                        default: ;              // Stray byte, stay idle
                    endcase
                end
                S_FIRST: begin
                    case (kind_q)
                        K_WR: begin
                            waddr_en = 1'b1;    // Address now, data next
                            state_d  = S_SECOND;
                        end
                        K_RD: begin
                            emit      = 1'b1;
                            op_d.kind = OP_READ;
                            state_d   = S_IDLE;
                        end
                        default: begin
                            emit      = 1'b1;   // Operand A into reg 0
                            op_d.addr = '0;
                            state_d   = S_SECOND;
                        end
                    endcase
                end
                S_SECOND: begin
                    emit = 1'b1;
                    if (kind_q == K_ALU) begin
                        op_d.addr = data_t'(1);   // Operand B into reg 1
                        state_d   = S_FUNC;
                    end else begin
                        op_d.addr = waddr_q;
                        state_d   = S_IDLE;
                    end
                end
                default: begin                    // Function frame
                    emit      = 1'b1;
                    op_d.kind = OP_ALU;
                    state_d   = S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q  <= S_IDLE;
            kind_q   <= K_WR;
            op_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            kind_q  <= kind_d;
            if (emit) begin
                op_valid <= 1'b1;
            end else if (op_ready) begin
                op_valid <= 1'b0;               // Taken by the executor
            end
        end
    end

    // Payload only, qualified by op_valid
    always_ff @(posedge CLK) begin
        if (waddr_en) begin
            waddr_q <= rx_data;
        end
        if (emit) begin
            op <= op_d;
        end
    end

endmodule

//--- rtl/op_executor.sv
`timescale 1ns/10ps

module op_executor import cmd_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic CLK,
    input  logic RST,
    input  logic op_valid,
    input  op_t  op,
    output logic op_ready,
    output logic rsp_valid,
    output rsp_t rsp,
    input  logic rsp_ready
);

    logic                  accept;
    logic                  wr_en;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  pend_q;       // Read or ALU op, result due next edge
    logic                  pend_alu_q;   // Pending op is ALU, else read
    alu_fun_e              pend_fun_q;
    data_t                 rd_data;
    data_t                 reg0;
    data_t                 reg1;
    alu_out_t              alu_result;

    // One response in the pipe at most
    assign op_ready = !pend_q && !rsp_valid;
    assign accept   = op_valid && op_ready;
    assign addr     = op.addr[ADDR_WIDTH-1:0];   // Upper address bits ignored
    assign wr_en    = accept && (op.kind == OP_WRITE);
    assign rd_en    = accept && (op.kind == OP_READ);

    reg_file #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_reg_file (
        .CLK     (CLK),
        .RST     (RST),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wr_data (op.data),
        .rd_data (rd_data),
        .reg0    (reg0),
        .reg1    (reg1)
    );

    alu_unit u_alu (
        .opa    (reg0),
        .opb    (reg1),
        .fun    (pend_fun_q),
        .result (alu_result)
    );

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pend_q    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            pend_q <= accept && (op.kind != OP_WRITE);
            if (pend_q) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;               // Serializer took it
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            pend_alu_q <= (op.kind == OP_ALU);
            pend_fun_q <= op.fun;
        end
        // Result register, loaded only while rsp_valid is low
        if (pend_q) begin
            rsp.two_bytes <= pend_alu_q;
            rsp.value     <= pend_alu_q ? alu_result : alu_out_t'(rd_data);
        end
    end

endmodule

//--- rtl/response_serializer.sv
`timescale 1ns/10ps

module response_serializer import cmd_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  logic  rsp_valid,
    input  rsp_t  rsp,
    output logic  rsp_ready,
    input  logic  fifo_full,
    output logic  fifo_winc,
    output data_t fifo_wdata
);

    logic busy_q;      // Bytes left to write
    logic idx_q;       // 0 low byte, 1 high byte
    rsp_t rsp_q;

    assign rsp_ready = !busy_q;
    // Never write into a full FIFO
    assign fifo_winc  = busy_q && !fifo_full;
    assign fifo_wdata = idx_q ? rsp_q.value[ALU_OUT_W-1:DATA_W] : rsp_q.value[DATA_W-1:0];

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            busy_q <= 1'b0;
            idx_q  <= 1'b0;
        end else if (rsp_valid && rsp_ready) begin
            busy_q <= 1'b1;
            idx_q  <= 1'b0;                      // Low byte first
        end else if (fifo_winc) begin
            if (!idx_q && rsp_q.two_bytes) begin
                idx_q <= 1'b1;
            end else begin
                busy_q <= 1'b0;                  // Last byte out
                idx_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rsp_valid && rsp_ready) begin
            rsp_q <= rsp;
        end
    end

endmodule

//--- rtl/cmd_proc_top.sv
`timescale 1ns/10ps

module cmd_proc_top import cmd_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic  CLK,
    input  logic  RST,
    input  logic  rx_valid,
    input  data_t rx_data,
    input  logic  fifo_full,
    output logic  fifo_winc,
    output data_t fifo_wdata
);

    // Decode to execute
    logic op_valid;
    op_t  op;
    logic op_ready;
    // Execute to serialize
    logic rsp_valid;
    rsp_t rsp;
    logic rsp_ready;

    frame_decoder u_decoder (
        .CLK      (CLK),
        .RST      (RST),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .op_valid (op_valid),
        .op       (op),
        .op_ready (op_ready)
    );

    op_executor #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_executor (
        .CLK       (CLK),
        .RST       (RST),
        .op_valid  (op_valid),
        .op        (op),
        .op_ready  (op_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    response_serializer u_serializer (
        .CLK        (CLK),
        .RST        (RST),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .fifo_full  (fifo_full),
        .fifo_winc  (fifo_winc),
        .fifo_wdata (fifo_wdata)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic CLK,
    output logic RST
);

    localparam time HALF_PERIOD = 10ns;   // 20 ns period

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // Low for two rising edges, released on a falling edge
    initial begin
        RST = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;
    end

endmodule

//--- dv/cmd_proc_assert.sv
`timescale 1ns/10ps

module cmd_proc_assert import cmd_pkg::*; (
    input logic CLK,
    input logic RST,
    input logic fifo_full,
    input logic fifo_winc,
    input logic op_valid,
    input op_t  op,
    input logic op_ready,
    input logic rsp_valid,
    input rsp_t rsp,
    input logic rsp_ready
);

    int fails = 0;    // Failed assertion count

    // FIFO write strobe must respect full
    a_no_write_when_full: assert property (
        @(posedge CLK) disable iff (!RST) !(fifo_winc && fifo_full)
    ) else begin
        fails++;
        $error("fifo_winc high while fifo_full is high");
    end

    // Held operation stays put until the executor takes it
    a_op_stable: assert property (
        @(posedge CLK) disable iff (!RST)
        (op_valid && !op_ready) |=> (op_valid && $stable(op))
    ) else begin
        fails++;
        $error("op changed or dropped before acceptance");
    end

    // Pending response stays put until the serializer takes it
    a_rsp_stable: assert property (
        @(posedge CLK) disable iff (!RST)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else begin
        fails++;
        $error("rsp changed or dropped before acceptance");
    end

endmodule

//--- dv/cmd_proc_tb.sv
`timescale 1ns/10ps

module cmd_proc_tb import cmd_pkg::*; ();

    localparam int          ADDR_WIDTH = 4;
    localparam int          NUM_CMDS   = 300;
    localparam int          CMD_CYCLES = 60;      // Generous bound per command
    localparam int          MAX_CYCLES = NUM_CMDS * CMD_CYCLES + 2000;
    localparam logic [31:0] SEED       = 32'ha96bbe32;

    logic  CLK;
    logic  RST;
    logic  rx_valid;
    data_t rx_data;
    logic  fifo_full;
    logic  fifo_winc;
    data_t fifo_wdata;

    integer seed;
    integer full_seed;                            // Separate stream for back-pressure
    int     errors;
    int     bytes_checked;
    int     cycles;
    int     sel;
    data_t  model [2**ADDR_WIDTH];                // Register file model
    data_t  exp_q [$];                            // Bytes the FIFO should see, in order
    data_t  addr_b;

    tb_clock_gen u_clk (.CLK (CLK), .RST (RST));

    cmd_proc_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) uut (
        .CLK        (CLK),
        .RST        (RST),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .fifo_full  (fifo_full),
        .fifo_winc  (fifo_winc),
        .fifo_wdata (fifo_wdata)
    );

    bind cmd_proc_top cmd_proc_assert u_assert (
        .CLK (CLK), .RST (RST), .fifo_full (fifo_full), .fifo_winc (fifo_winc),
        .op_valid (op_valid), .op (op), .op_ready (op_ready),
        .rsp_valid (rsp_valid), .rsp (rsp), .rsp_ready (rsp_ready)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        rand_below = {$random(seed)} % n;
    endfunction

    // ALU reference from the function table, operands zero-extended
    function automatic alu_out_t alu_model(input data_t a, input data_t b, input logic [3:0] f);
        alu_out_t x;
        alu_out_t y;
        x = {8'h00, a};
        y = {8'h00, b};
        case (f)
            4'd0:    alu_model = x + y;
            4'd1:    alu_model = x - y;
            4'd2:    alu_model = x * y;
            4'd3:    alu_model = (y == 16'd0) ? 16'd0 : x / y;
            4'd4:    alu_model = x & y;
            4'd5:    alu_model = x | y;
            4'd6:    alu_model = x ^ y;
            4'd7:    alu_model = (x == y) ? 16'd1 : 16'd0;
            4'd8:    alu_model = (x > y) ? 16'd1 : 16'd0;
            4'd9:    alu_model = x >> 1;
            4'd10:   alu_model = x << 1;
            default: alu_model = 16'd0;           // Unused codes
        endcase
    endfunction

    // Mostly random address bytes, often hitting the ALU operand registers
    function automatic data_t pick_addr();
        if (rand_below(4) == 0) begin
            pick_addr = data_t'(rand_below(2));
        end else begin
            pick_addr = data_t'(rand_below(256));  // Upper bits must be ignored
        end
    endfunction

    // All tasks start and end 2 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #2;
        end
    endtask

    task automatic send_byte(input data_t b);
        rx_valid = 1'b1;
        rx_data  = b;
        @(posedge CLK);
        #2;
        rx_valid = 1'b0;
        idle_cycles(rand_below(3));               // Gap of 0 to 2 cycles
    endtask

    task automatic cmd_write(input data_t addr, input data_t data);
        send_byte(CMD_RF_WR);
        send_byte(addr);
        send_byte(data);
        model[addr[ADDR_WIDTH-1:0]] = data;
    endtask

    task automatic cmd_read(input data_t addr);
        send_byte(CMD_RF_RD);
        exp_q.push_back(model[addr[ADDR_WIDTH-1:0]]);
        send_byte(addr);
    endtask

    task automatic cmd_alu(input logic with_ops);
        data_t    a;
        data_t    b;
        data_t    fbyte;
        alu_out_t r;
        a     = data_t'(rand_below(256));
        b     = data_t'(rand_below(256));
        fbyte = data_t'(rand_below(256));         // Only the low nibble selects
        if (with_ops) begin
            send_byte(CMD_ALU_OP);
            send_byte(a);
            send_byte(b);
            model[0] = a;                         // Operands land in regs 0 and 1
            model[1] = b;
        end else begin
            send_byte(CMD_ALU_NOP);
        end
        r = alu_model(model[0], model[1], fbyte[3:0]);
        exp_q.push_back(r[7:0]);                  // Low byte first
        exp_q.push_back(r[15:8]);
        send_byte(fbyte);
    endtask

    // Idle bytes that are not command codes
    task automatic send_stray(input int n);
        data_t b;
        repeat (n) begin
            b = data_t'(rand_below(256));
            if (b == CMD_RF_WR || b == CMD_RF_RD || b == CMD_ALU_OP || b == CMD_ALU_NOP) begin
                b = b ^ 8'h01;
            end
            send_byte(b);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(4);
    endtask

    // Random back-pressure, about 30% full
    always @(posedge CLK) begin
        #2;
        fifo_full = ({$random(full_seed)} % 100) < 30;
    end

    // FIFO sink, sampled mid-cycle where inputs and strobe are settled
    always @(negedge CLK) begin
        if (fifo_winc) begin
            if (fifo_full) begin
                errors++;
                $display("Error at %0d ns: byte written while fifo_full high", $time);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0d ns: unexpected byte %02h", $time, fifo_wdata);
            end else begin
                bytes_checked++;
                if (fifo_wdata !== exp_q[0]) begin
                    errors++;
                    $display("Error at %0d ns: got %02h, expected %02h",
                             $time, fifo_wdata, exp_q[0]);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        seed          = SEED;
        full_seed     = ~SEED;
        errors        = 0;
        bytes_checked = 0;
        cycles        = 0;
        rx_valid      = 1'b0;
        rx_data       = '0;
        fifo_full     = 1'b0;
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            model[i] = '0;
        end
        wait (RST === 1'b1);
        @(posedge CLK);
        #2;
        for (int n = 0; n < NUM_CMDS; n++) begin
            sel = rand_below(10);
            case (sel)
                0, 1: begin                       // Write then read back
                    addr_b = pick_addr();
                    cmd_write(addr_b, data_t'(rand_below(256)));
                    wait_drain();
                    cmd_read(addr_b);
                end
                2, 9: cmd_read(pick_addr());
                3, 4: cmd_alu(1'b1);
                5, 6: cmd_alu(1'b0);
                7:    cmd_write(pick_addr(), data_t'(rand_below(256)));
                default: send_stray(1 + rand_below(3));
            endcase
            wait_drain();
            idle_cycles(rand_below(4));
        end
        idle_cycles(20);                          // Catch any late stray write
        if (exp_q.size() != 0) begin
            errors++;
            $display("Expected bytes still missing at the end of the run");
        end
        $display("Summary: %0d commands, %0d bytes checked, %0d errors, %0d assertion failures",
                 NUM_CMDS, bytes_checked, errors, uut.u_assert.fails);
        if (errors == 0 && uut.u_assert.fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/cmd_pkg.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/frame_decoder.sv
rtl/op_executor.sv
rtl/response_serializer.sv
rtl/cmd_proc_top.sv
dv/tb_clock_gen.sv
dv/cmd_proc_assert.sv
dv/cmd_proc_tb.sv

//--- Makefile
TOP = cmd_proc_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
